// File: panel_pkg.sv
/* Shared widths, opcodes and pipeline structs for the LED panel fill engine.
   Imported by every stage of the command pipeline. */
package panel_pkg;

    parameter int ROW_BITS = 5;         // Up to 32 rows
    parameter int COL_BITS = 6;         // Up to 64 columns
    parameter int BYTES_PER_PIXEL = 3;
    parameter int PIX_SEL_BITS = 2;

    // Command opcodes sent as the first byte of every command
    parameter logic [7:0] OP_FILL_PANEL = 8'h01;
    parameter logic [7:0] OP_FILL_RECT = 8'h02;

    typedef logic [ROW_BITS-1:0] row_t;
    typedef logic [COL_BITS-1:0] col_t;

    // Sizes carry one bit more than the address so a full panel edge fits
    typedef logic [ROW_BITS:0] row_cnt_t;
    typedef logic [COL_BITS:0] col_cnt_t;

    // First color byte received sits in the top byte
    typedef logic [8*BYTES_PER_PIXEL-1:0] color_t;

    typedef struct packed {
        col_t     x;        // Column origin
        row_t     y;        // Row origin
        col_cnt_t width;
        row_cnt_t height;
        color_t   color;
    } fill_job_t;

    typedef struct packed {
        row_t                    row;
        col_t                    column;
        logic [PIX_SEL_BITS-1:0] pixel;
        logic [7:0]              data;
    } pixel_write_t;

endpackage

// File: cmd_decode.sv
/* Byte-serial command decoder for the fill engine. Collects one fill command
   from the host and hands a single fill job to the area walker. */
`timescale 1ns/1ps

module cmd_decode #(
    parameter int PANEL_WIDTH = 64,
    parameter int PANEL_HEIGHT = 32
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [7:0]           data_in,
    input  logic                 data_valid,
    input  logic                 walk_done,
    output logic                 ready,
    output panel_pkg::fill_job_t job,
    output logic                 job_valid
);
    import panel_pkg::*;

    typedef enum logic [1:0] {
        S_OPCODE,
        S_GEOM,
        S_COLOR,
        S_BUSY
    } state_t;

    state_t state;
    logic [1:0] remaining;          // Bytes still expected in this phase minus one
    logic [7:0] x_raw, y_raw, w_raw, h_raw;
    color_t color;

    assign ready = (state != S_BUSY);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_OPCODE;
            remaining <= '0;
            job_valid <= 1'b0;
        end else begin
            job_valid <= 1'b0;
            case (state)
                S_OPCODE: begin
                    if (data_valid) begin
                        if (data_in == OP_FILL_PANEL) begin
                            state <= S_COLOR;
                            remaining <= 2'(BYTES_PER_PIXEL - 1);
                        end else if (data_in == OP_FILL_RECT) begin
                            state <= S_GEOM;
                            remaining <= 2'd3;
                        end
                    end
                end
                S_GEOM: begin
                    if (data_valid) begin
                        remaining <= remaining - 2'd1;
                        if (remaining == 2'd0) begin
                            state <= S_COLOR;
                            remaining <= 2'(BYTES_PER_PIXEL - 1);
                        end
                    end
                end
                S_COLOR: begin
                    if (data_valid) begin
                        remaining <= remaining - 2'd1;
                        if (remaining == 2'd0) begin
                            state <= S_BUSY;
                            job_valid <= 1'b1;
                        end
                    end
                end
                default: begin
                    if (walk_done) state <= S_OPCODE;
                end
            endcase
        end
    end

    // Command payload capture
    always_ff @(posedge clk) begin
        if (state == S_OPCODE && data_valid && data_in == OP_FILL_PANEL) begin
            x_raw <= 8'd0;
            y_raw <= 8'd0;
            w_raw <= 8'(PANEL_WIDTH);
            h_raw <= 8'(PANEL_HEIGHT);
        end
        if (state == S_GEOM && data_valid) begin
            case (remaining)
                2'd3: x_raw <= data_in;
                2'd2: y_raw <= data_in;
                2'd1: w_raw <= data_in;
                default: h_raw <= data_in;
            endcase
        end
        if (state == S_COLOR && data_valid) color <= {color[8*BYTES_PER_PIXEL-9:0], data_in};
    end

    // An origin off the panel becomes an empty job, and sizes saturate at the panel edge
    always_comb begin
        job.x = x_raw[COL_BITS-1:0];
        job.y = y_raw[ROW_BITS-1:0];
        if (x_raw >= PANEL_WIDTH)
            job.width = '0;
        else if (w_raw > PANEL_WIDTH)
            job.width = col_cnt_t'(PANEL_WIDTH);
        else
            job.width = col_cnt_t'(w_raw);
        if (y_raw >= PANEL_HEIGHT)
            job.height = '0;
        else if (h_raw > PANEL_HEIGHT)
            job.height = row_cnt_t'(PANEL_HEIGHT);
        else
            job.height = row_cnt_t'(h_raw);
        job.color = color;
    end

    // The walker reports back only for the one job in flight, never in the issue cycle
    assert property (@(posedge clk) disable iff (reset)
        walk_done |-> (state == S_BUSY) && !job_valid);

endmodule

// File: area_walker.sv
/* Clips a fill job to the panel and emits one frame buffer byte write per
   cycle, row-major, with the three color bytes of each pixel in order. */
`timescale 1ns/1ps

module area_walker #(
    parameter int PANEL_WIDTH = 64,
    parameter int PANEL_HEIGHT = 32
) (
    input  logic                    clk,
    input  logic                    reset,
    input  panel_pkg::fill_job_t    job,
    input  logic                    job_valid,
    output panel_pkg::pixel_write_t wr,
    output logic                    wr_valid,
    output logic                    walk_done
);
    import panel_pkg::*;

    logic active;
    row_t row;
    col_t col;
    logic [PIX_SEL_BITS-1:0] sel;
    col_t x_start;
    col_cnt_t end_col;              // One past the last column
    row_cnt_t end_row;              // One past the last row
    color_t color;

    logic [COL_BITS+1:0] col_sum;
    logic [ROW_BITS+1:0] row_sum;
    logic empty;
    logic last_col, last_row, last_sel;

    always_comb begin
        col_sum = {2'b00, job.x} + {1'b0, job.width};
        row_sum = {2'b00, job.y} + {1'b0, job.height};
        empty = (job.width == '0) || (job.height == '0) ||
                (job.x >= PANEL_WIDTH) || (job.y >= PANEL_HEIGHT);
    end

    assign last_sel = (sel == PIX_SEL_BITS'(BYTES_PER_PIXEL - 1));
    assign last_col = (({1'b0, col} + 1'b1) == end_col);
    assign last_row = (({1'b0, row} + 1'b1) == end_row);

    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
            walk_done <= 1'b0;
            row <= '0;
            col <= '0;
            sel <= '0;
        end else begin
            walk_done <= 1'b0;
            if (job_valid) begin
                if (empty) begin
                    walk_done <= 1'b1;  // Nothing to paint
                end else begin
                    active <= 1'b1;
                    row <= job.y;
                    col <= job.x;
                    sel <= '0;
                end
            end else if (active) begin
                if (last_sel) begin
                    sel <= '0;
                    if (last_col) begin
                        col <= x_start;
                        if (last_row) begin
                            active <= 1'b0;
                            walk_done <= 1'b1;
                        end else begin
                            row <= row + 1'b1;
                        end
                    end else begin
                        col <= col + 1'b1;
                    end
                end else begin
                    sel <= sel + 1'b1;
                end
            end
        end
    end

    // Clipped bounds and color are held for the whole walk
    always_ff @(posedge clk) begin
        if (job_valid) begin
            x_start <= job.x;
            color <= job.color;
            end_col <= (col_sum > PANEL_WIDTH) ? col_cnt_t'(PANEL_WIDTH) : col_sum[COL_BITS:0];
            end_row <= (row_sum > PANEL_HEIGHT) ? row_cnt_t'(PANEL_HEIGHT) : row_sum[ROW_BITS:0];
        end
    end

    always_comb begin
        wr.row = row;
        wr.column = col;
        wr.pixel = sel;
        case (sel)
            2'd0: wr.data = color[23:16];   // Most significant byte first
            2'd1: wr.data = color[15:8];
            default: wr.data = color[7:0];
        endcase
    end

    assign wr_valid = active;

    assert property (@(posedge clk) disable iff (reset)
        wr_valid |-> (wr.row < PANEL_HEIGHT) && (wr.column < PANEL_WIDTH) &&
                     (wr.pixel < BYTES_PER_PIXEL));

    // The decoder must wait for walk_done before issuing the next job
    assert property (@(posedge clk) disable iff (reset) job_valid |-> !active);

endmodule

// File: frame_buffer.sv
/* Byte-wide pixel memory of the panel. The walker writes through one port
   and the rest of the system reads back through a registered port. */
`timescale 1ns/1ps

module frame_buffer #(
    parameter int PANEL_WIDTH = 64,
    parameter int PANEL_HEIGHT = 32
) (
    input  logic                                 clk,
    input  panel_pkg::pixel_write_t              wr,
    input  logic                                 wr_valid,
    input  logic [panel_pkg::ROW_BITS-1:0]       rd_row,
    input  logic [panel_pkg::COL_BITS-1:0]       rd_column,
    input  logic [panel_pkg::PIX_SEL_BITS-1:0]   rd_pixel,
    output logic [7:0]                           rd_data
);
    import panel_pkg::*;

    localparam int DEPTH = PANEL_HEIGHT * PANEL_WIDTH * BYTES_PER_PIXEL;
    localparam int ADDR_BITS = $clog2(DEPTH);

    logic [7:0] mem [DEPTH];
    logic [ADDR_BITS-1:0] wr_addr;
    logic [ADDR_BITS-1:0] rd_addr;

    // Row-major layout with the three bytes of a pixel side by side
    function automatic logic [ADDR_BITS-1:0] flat_addr(
        input row_t                    r,
        input col_t                    c,
        input logic [PIX_SEL_BITS-1:0] p
    );
        int unsigned a;
        a = (int'(r) * PANEL_WIDTH + int'(c)) * BYTES_PER_PIXEL + int'(p);
        return a[ADDR_BITS-1:0];
    endfunction

    assign wr_addr = flat_addr(wr.row, wr.column, wr.pixel);
    assign rd_addr = flat_addr(rd_row, rd_column, rd_pixel);

    always_ff @(posedge clk) begin
        if (wr_valid) mem[wr_addr] <= wr.data;
    end

    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];    // Old data on a same-cycle write to the same byte
    end

endmodule

// File: panel_fill_top.sv
/* Top level of the panel fill engine. Chains decoder, walker and frame buffer
   and sets the panel size for all three. */
`timescale 1ns/1ps

module panel_fill_top #(
    parameter int PANEL_WIDTH = 64,
    parameter int PANEL_HEIGHT = 32
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic [7:0]                         data_in,
    input  logic                               data_valid,
    output logic                               ready,
    output logic                               done,
    input  logic [panel_pkg::ROW_BITS-1:0]     rd_row,
    input  logic [panel_pkg::COL_BITS-1:0]     rd_column,
    input  logic [panel_pkg::PIX_SEL_BITS-1:0] rd_pixel,
    output logic [7:0]                         rd_data
);
    import panel_pkg::*;

    fill_job_t job;
    logic job_valid;
    pixel_write_t wr;
    logic wr_valid;
    logic walk_done;

    cmd_decode #(
        .PANEL_WIDTH(PANEL_WIDTH),
        .PANEL_HEIGHT(PANEL_HEIGHT)
    ) u_cmd_decode (
        .clk(clk),
        .reset(reset),
        .data_in(data_in),
        .data_valid(data_valid),
        .walk_done(walk_done),
        .ready(ready),
        .job(job),
        .job_valid(job_valid)
    );

    area_walker #(
        .PANEL_WIDTH(PANEL_WIDTH),
        .PANEL_HEIGHT(PANEL_HEIGHT)
    ) u_area_walker (
        .clk(clk),
        .reset(reset),
        .job(job),
        .job_valid(job_valid),
        .wr(wr),
        .wr_valid(wr_valid),
        .walk_done(walk_done)
    );

    frame_buffer #(
        .PANEL_WIDTH(PANEL_WIDTH),
        .PANEL_HEIGHT(PANEL_HEIGHT)
    ) u_frame_buffer (
        .clk(clk),
        .wr(wr),
        .wr_valid(wr_valid),
        .rd_row(rd_row),
        .rd_column(rd_column),
        .rd_pixel(rd_pixel),
        .rd_data(rd_data)
    );

    assign done = walk_done;

endmodule

// File: tb_panel_fill.sv
/* Self-checking testbench for the panel fill engine. Sends random fill commands,
   checks done timing against a frame model and reads the whole buffer back. */
`timescale 1ns/1ps

module tb_panel_fill;
    import panel_pkg::*;

    localparam int PANEL_WIDTH = 64;
    localparam int PANEL_HEIGHT = 32;
    localparam int NUM_CMDS = 40;
    localparam int RESET_CYCLES = 8;
    localparam int FRAME_BYTES = PANEL_WIDTH * PANEL_HEIGHT * BYTES_PER_PIXEL;
    // Worst command is a few junk and command bytes, a full panel walk and a full read-back
    localparam longint CMD_CYCLES = 24 + 2 * FRAME_BYTES + 8;
    localparam longint WATCHDOG_NS = (NUM_CMDS * CMD_CYCLES + RESET_CYCLES + 200) * 100;

    logic clk;
    logic reset;
    logic [7:0] data_in;
    logic data_valid;
    logic ready;
    logic done;
    logic [ROW_BITS-1:0] rd_row;
    logic [COL_BITS-1:0] rd_column;
    logic [PIX_SEL_BITS-1:0] rd_pixel;
    logic [7:0] rd_data;

    logic [31:0] lfsr_state = 32'hb15cade4;
    logic [7:0] frame_model [PANEL_HEIGHT][PANEL_WIDTH][BYTES_PER_PIXEL];

    panel_fill_top #(
        .PANEL_WIDTH(PANEL_WIDTH),
        .PANEL_HEIGHT(PANEL_HEIGHT)
    ) DUT (
        .clk(clk),
        .reset(reset),
        .data_in(data_in),
        .data_valid(data_valid),
        .ready(ready),
        .done(done),
        .rd_row(rd_row),
        .rd_column(rd_column),
        .rd_pixel(rd_pixel),
        .rd_data(rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout at %0t: the engine stopped making progress", $time);
        $display("Test FAILED");
        $fatal(1, "Watchdog expired");
    end

    // Galois LFSR stepped once per bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr_state[0]};
            if (lfsr_state[0])
                lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
            else
                lfsr_state = lfsr_state >> 1;
        end
        return value;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s expected %0h, actual %0h",
                     $time, name, expected, actual);
            $display("Test FAILED");
            $fatal(1, "Stopping at first error");
        end
    endtask

    // Paints the clipped rectangle into the model and returns its pixel count
    function automatic int paint_model(input int x, input int y, input int w, input int h,
                                       input logic [23:0] color);
        int x_end;
        int y_end;
        if (x >= PANEL_WIDTH || y >= PANEL_HEIGHT) return 0;
        x_end = (x + w > PANEL_WIDTH) ? PANEL_WIDTH : x + w;
        y_end = (y + h > PANEL_HEIGHT) ? PANEL_HEIGHT : y + h;
        for (int r = y; r < y_end; r++) begin
            for (int c = x; c < x_end; c++) begin
                for (int p = 0; p < BYTES_PER_PIXEL; p++) begin
                    frame_model[r][c][p] = color[23 - 8 * p -: 8];  // Byte 0 is the top byte
                end
            end
        end
        return (x_end - x) * (y_end - y);
    endfunction

    // Called on a falling edge and returns on the falling edge after the byte was taken
    task automatic send_byte(input logic [7:0] value);
        check_value("ready", 1, ready);
        check_value("done", 0, done);
        data_in = value;
        data_valid = 1'b1;
        @(negedge clk);
        data_valid = 1'b0;
    endtask

    task automatic wait_for_done(input int expected);
        int count;
        count = 1;                  // The edge that took the last byte
        while (!done && count < expected + 4) begin
            check_value("ready", 0, ready);
            // Stray bytes while busy must be ignored
            if (take_bits(2) == 0) begin
                data_in = take_bits(8);
                data_valid = 1'b1;
            end
            @(negedge clk);
            data_valid = 1'b0;
            count++;
        end
        check_value("done", 1, done);
        check_value("done latency", expected, count);
        check_value("ready", 0, ready);
        @(negedge clk);
        check_value("done", 0, done);
        check_value("ready", 1, ready);
    endtask

    task automatic run_command(input logic [7:0] bytes [$], input int pixels);
        foreach (bytes[i]) send_byte(bytes[i]);
        wait_for_done(2 + 3 * pixels);
    endtask

    // Pipelined read where each address is checked one cycle after it is driven
    task automatic read_back();
        int pr;
        int pc;
        int pp;
        for (int k = 0; k <= FRAME_BYTES; k++) begin
            if (k > 0) begin
                pr = (k - 1) / (PANEL_WIDTH * BYTES_PER_PIXEL);
                pc = ((k - 1) / BYTES_PER_PIXEL) % PANEL_WIDTH;
                pp = (k - 1) % BYTES_PER_PIXEL;
                check_value($sformatf("rd_data row %0d column %0d pixel %0d", pr, pc, pp),
                            frame_model[pr][pc][pp], rd_data);
            end
            if (k < FRAME_BYTES) begin
                rd_row = ROW_BITS'(k / (PANEL_WIDTH * BYTES_PER_PIXEL));
                rd_column = COL_BITS'((k / BYTES_PER_PIXEL) % PANEL_WIDTH);
                rd_pixel = PIX_SEL_BITS'(k % BYTES_PER_PIXEL);
            end
            @(negedge clk);
        end
    endtask

    initial begin
        logic [7:0] bytes [$];
        logic [7:0] junk;
        logic [23:0] color;
        int x;
        int y;
        int w;
        int h;
        int pixels;
        int junk_count;

        reset = 1'b1;
        data_in = '0;
        data_valid = 1'b0;
        rd_row = '0;
        rd_column = '0;
        rd_pixel = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        check_value("ready", 1, ready);
        check_value("done", 0, done);

        for (int cmd = 0; cmd < NUM_CMDS; cmd++) begin
            // Unknown opcodes in front of the real command
            junk_count = (cmd == 0) ? 0 : take_bits(2);
            for (int j = 0; j < junk_count; j++) begin
                junk = take_bits(8);
                if (junk == OP_FILL_PANEL || junk == OP_FILL_RECT) junk = junk ^ 8'h80;
                send_byte(junk);
            end

            color = take_bits(24);
            bytes.delete();
            if (cmd == 0 || take_bits(3) == 0) begin
                bytes.push_back(OP_FILL_PANEL);
                pixels = paint_model(0, 0, PANEL_WIDTH, PANEL_HEIGHT, color);
                $display("Command %0d: fill panel with %06h", cmd, color);
            end else begin
                x = (take_bits(3) == 0) ? take_bits(8) : take_bits(6);
                y = (take_bits(3) == 0) ? take_bits(8) : take_bits(5);
                w = (take_bits(4) == 0) ? 0 : ((take_bits(3) == 0) ? take_bits(8) : take_bits(5));
                h = (take_bits(4) == 0) ? 0 : ((take_bits(3) == 0) ? take_bits(8) : take_bits(4));
                bytes.push_back(OP_FILL_RECT);
                bytes.push_back(8'(x));
                bytes.push_back(8'(y));
                bytes.push_back(8'(w));
                bytes.push_back(8'(h));
                pixels = paint_model(x, y, w, h, color);
                $display("Command %0d: rectangle x %0d y %0d w %0d h %0d with %06h",
                         cmd, x, y, w, h, color);
            end
            bytes.push_back(color[23:16]);
            bytes.push_back(color[15:8]);
            bytes.push_back(color[7:0]);

            run_command(bytes, pixels);
            read_back();
        end

        $display("Test OK");
        $finish;
    end

endmodule

// File: tb.f
panel_pkg.sv
cmd_decode.sv
area_walker.sv
frame_buffer.sv
panel_fill_top.sv
tb_panel_fill.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the panel fill testbench with Verilator and runs it.
# The exit status is the simulator's own status.

set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module tb_panel_fill -Mdir obj_dir -f tb.f; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_panel_fill
status=$?

if [ "$status" -ne 0 ]; then
    echo "Simulation returned status $status"
fi

exit "$status"
